//--- Bender.yml
package:
  name: rv_decoder

sources:
  - files:
      - hdl/rv_decode_pkg.sv
      - hdl/op_decode.sv
      - hdl/imm_gen.sv
      - hdl/decode_stage.sv
      - hdl/rv_decoder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_decoder.sv

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  rv_decode_pkg::instr_t   instr,
    input  rv_decode_pkg::op_t      op_next,
    input  rv_decode_pkg::fmt_t     fmt,
    input  rv_decode_pkg::word_t    imm_next,
    output logic                    out_valid,
    output rv_decode_pkg::op_t      op,
    output rv_decode_pkg::reg_idx_t rs1,
    output rv_decode_pkg::reg_idx_t rs2,
    output rv_decode_pkg::reg_idx_t rd,
    output rv_decode_pkg::word_t    imm,
    output logic                    has_imm
);
    import rv_decode_pkg::*;

    logic     use_rs1;
    logic     use_rs2;
    logic     use_rd;
    logic     has_imm_next;
    reg_idx_t rs1_next;
    reg_idx_t rs2_next;
    reg_idx_t rd_next;

    // which fields each format reads or writes.
    assign use_rs1 = fmt inside {fmt_r, fmt_i, fmt_shift, fmt_s, fmt_b};
    assign use_rs2 = fmt inside {fmt_r, fmt_s, fmt_b};
    assign use_rd  = fmt inside {fmt_r, fmt_i, fmt_shift, fmt_u, fmt_j};

    assign has_imm_next = !(fmt inside {fmt_r, fmt_none});

    // unused fields read as zero.
    assign rs1_next = use_rs1 ? instr[19:15] : '0;
    assign rs2_next = use_rs2 ? instr[24:20] : '0;
    assign rd_next  = use_rd  ? instr[11:7]  : '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
            op        <= op_invalid;
            rs1       <= '0;
            rs2       <= '0;
            rd        <= '0;
            imm       <= '0;
            has_imm   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // results hold while no instruction arrives.
            if (in_valid) begin
                op      <= op_next;
                rs1     <= rs1_next;
                rs2     <= rs2_next;
                rd      <= rd_next;
                imm     <= imm_next;
                has_imm <= has_imm_next;
            end
        end
    end

    a_valid_follow: assert property (
        @(posedge clk) disable iff (!rst) 1'b1 |=> out_valid == $past(in_valid)
    ) else $error("decode_stage: out_valid does not follow in_valid");

    // imm_gen must give zero wherever has_imm is low.
    a_no_imm_zero: assert property (
        @(posedge clk) disable iff (!rst) !has_imm |-> imm == '0
    ) else $error("decode_stage: nonzero imm without has_imm");

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::instr_t instr,
    input  rv_decode_pkg::fmt_t   fmt,
    output rv_decode_pkg::word_t  imm_next
);
    import rv_decode_pkg::*;

    logic sign;

    // every signed layout takes its sign from bit 31.
    assign sign = instr[31];

    always_comb begin
        case (fmt)
            fmt_i: begin
                imm_next = {{20{sign}}, instr[31:20]};
            end
            fmt_shift: begin
                // shamt, zero-extended.
                imm_next = {27'b0, instr[24:20]};
            end
            fmt_s: begin
                imm_next = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            fmt_b: begin
                imm_next = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            fmt_u: begin
                imm_next = {instr[31:12], 12'b0};
            end
            fmt_j: begin
                imm_next = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                // r-type and invalid carry no immediate
                imm_next = '0;
            end
        endcase
    end

    // branch and jump targets are halfword aligned.
    a_align: assert final (!(fmt inside {fmt_b, fmt_j}) || imm_next[0] == 1'b0)
        else $error("imm_gen: odd offset for branch or jump");

endmodule

//--- hdl/op_decode.sv
`timescale 1ns/1ps

module op_decode (
    input  rv_decode_pkg::instr_t instr,
    output rv_decode_pkg::op_t    op_next,
    output rv_decode_pkg::fmt_t   fmt
);
    import rv_decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // bit 30 picks sub and sra.
    assign alt    = instr[30];

    always_comb begin
        op_next = op_invalid;
        fmt     = fmt_none;
        if (instr != '0) begin
            case (opcode)
                opc_lui: begin
                    op_next = op_lui;
                    fmt     = fmt_u;
                end
                opc_auipc: begin
                    op_next = op_auipc;
                    fmt     = fmt_u;
                end
                opc_jal: begin
                    op_next = op_jal;
                    fmt     = fmt_j;
                end
                opc_jalr: begin
                    if (funct3 == 3'b000) begin
                        op_next = op_jalr;
                        fmt     = fmt_i;
                    end
                end
                opc_branch: begin
                    fmt = fmt_b;
                    case (funct3)
                        3'b000:  op_next = op_beq;
                        3'b001:  op_next = op_bne;
                        3'b100:  op_next = op_blt;
                        3'b101:  op_next = op_bge;
                        3'b110:  op_next = op_bltu;
                        3'b111:  op_next = op_bgeu;
                        default: fmt = fmt_none;
                    endcase
                end
                opc_load: begin
                    fmt = fmt_i;
                    case (funct3)
                        3'b000:  op_next = op_lb;
                        3'b001:  op_next = op_lh;
                        3'b010:  op_next = op_lw;
                        3'b100:  op_next = op_lbu;
                        3'b101:  op_next = op_lhu;
                        default: fmt = fmt_none;
                    endcase
                end
                opc_store: begin
                    fmt = fmt_s;
                    case (funct3)
                        3'b000:  op_next = op_sb;
                        3'b001:  op_next = op_sh;
                        3'b010:  op_next = op_sw;
                        default: fmt = fmt_none;
                    endcase
                end
                opc_op_imm: begin
                    fmt = fmt_i;
                    case (funct3)
                        3'b000: op_next = op_add;
                        3'b010: op_next = op_slt;
                        3'b011: op_next = op_sltu;
                        3'b100: op_next = op_xor;
                        3'b110: op_next = op_or;
                        3'b111: op_next = op_and;
                        3'b001: begin
                            // slli has no bit 30 variant.
                            if (!alt) begin
                                op_next = op_sll;
                                fmt     = fmt_shift;
                            end else begin
                                fmt = fmt_none;
                            end
                        end
                        default: begin
                            op_next = alt ? op_sra : op_srl;
                            fmt     = fmt_shift;
                        end
                    endcase
                end
                opc_op: begin
                    fmt = fmt_r;
                    case (funct3)
                        3'b000: op_next = alt ? op_sub : op_add;
                        3'b001: op_next = op_sll;
                        3'b010: op_next = op_slt;
                        3'b011: op_next = op_sltu;
                        3'b100: op_next = op_xor;
                        3'b101: op_next = alt ? op_sra : op_srl;
                        3'b110: op_next = op_or;
                        default: op_next = op_and;
                    endcase
                    // only add and srl have an alternate form.
                    if (alt && funct3 != 3'b000 && funct3 != 3'b101) begin
                        op_next = op_invalid;
                        fmt     = fmt_none;
                    end
                end
                default: begin
                    op_next = op_invalid;
                    fmt     = fmt_none;
                end
            endcase
        end
    end

    // the register stage relies on fmt_none to zero an invalid result.
    a_fmt_none: assert final ((fmt == fmt_none) == (op_next == op_invalid))
        else $error("op_decode: fmt and op disagree on validity");

endmodule

//--- hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    // data word and field widths.
    localparam int unsigned xlen  = 32;
    localparam int unsigned reg_w = 5;
    localparam int unsigned opc_w = 7;

    typedef logic [xlen-1:0]  instr_t;
    typedef logic [xlen-1:0]  word_t;
    typedef logic [reg_w-1:0] reg_idx_t;
    typedef logic [opc_w-1:0] opcode_t;

    // operation codes, numbered as the execute unit expects them.
    typedef enum logic [4:0] {
        op_add     = 5'd0,
        op_and     = 5'd1,
        op_or      = 5'd2,
        op_sll     = 5'd3,
        op_srl     = 5'd4,
        op_slt     = 5'd5,
        op_sltu    = 5'd6,
        op_sra     = 5'd7,
        op_sub     = 5'd8,
        op_xor     = 5'd9,
        op_beq     = 5'd10,
        op_bge     = 5'd11,
        op_bne     = 5'd12,
        op_bgeu    = 5'd13,
        op_lui     = 5'd14,
        op_auipc   = 5'd15,
        op_jal     = 5'd16,
        op_jalr    = 5'd17,
        op_lb      = 5'd18,
        op_lh      = 5'd19,
        op_lw      = 5'd20,
        op_lbu     = 5'd21,
        op_lhu     = 5'd22,
        op_sb      = 5'd23,
        op_sh      = 5'd24,
        op_sw      = 5'd25,
        op_blt     = 5'd26,
        op_bltu    = 5'd27,
        op_invalid = 5'd31
    } op_t;

    // instruction formats, which select register fields and immediate layout.
    typedef enum logic [2:0] {
        fmt_r     = 3'd0,
        fmt_i     = 3'd1,
        fmt_shift = 3'd2,
        fmt_s     = 3'd3,
        fmt_b     = 3'd4,
        fmt_u     = 3'd5,
        fmt_j     = 3'd6,
        fmt_none  = 3'd7
    } fmt_t;

    // major opcodes, instr[6:0].
    localparam opcode_t opc_lui    = 7'b0110111;
    localparam opcode_t opc_auipc  = 7'b0010111;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_load   = 7'b0000011;
    localparam opcode_t opc_store  = 7'b0100011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_op     = 7'b0110011;

endpackage

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  rv_decode_pkg::instr_t   instr,
    output logic                    out_valid,
    output rv_decode_pkg::op_t      op,
    output rv_decode_pkg::reg_idx_t rs1,
    output rv_decode_pkg::reg_idx_t rs2,
    output rv_decode_pkg::reg_idx_t rd,
    output rv_decode_pkg::word_t    imm,
    output logic                    has_imm
);
    import rv_decode_pkg::*;

    op_t   op_next;
    fmt_t  fmt;
    word_t imm_next;

    // classify the word.
    op_decode u_op_decode (
        .instr   (instr),
        .op_next (op_next),
        .fmt     (fmt)
    );

    // immediate for the chosen format.
    imm_gen u_imm_gen (
        .instr    (instr),
        .fmt      (fmt),
        .imm_next (imm_next)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .op_next   (op_next),
        .fmt       (fmt),
        .imm_next  (imm_next),
        .out_valid (out_valid),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .has_imm   (has_imm)
    );

endmodule

//--- sim/tb_tests.svh
`ifndef tb_tests_svh
`define tb_tests_svh

// instruction word layouts of the base integer set.
function automatic instr_t r_word(input logic [6:0] f7, input reg_idx_t b, input reg_idx_t a,
                                  input logic [2:0] f3, input reg_idx_t d, input opcode_t opc);
    return {f7, b, a, f3, d, opc};
endfunction

function automatic instr_t i_word(input logic [11:0] v, input reg_idx_t a, input logic [2:0] f3,
                                  input reg_idx_t d, input opcode_t opc);
    return {v, a, f3, d, opc};
endfunction

function automatic instr_t s_word(input logic [11:0] v, input reg_idx_t b, input reg_idx_t a,
                                  input logic [2:0] f3);
    return {v[11:5], b, a, f3, v[4:0], opc_store};
endfunction

function automatic instr_t b_word(input logic [12:0] v, input reg_idx_t b, input reg_idx_t a,
                                  input logic [2:0] f3);
    return {v[12], v[10:5], b, a, f3, v[4:1], v[11], opc_branch};
endfunction

function automatic instr_t j_word(input logic [20:0] v, input reg_idx_t d);
    return {v[20], v[10:1], v[11], v[19:12], d, opc_jal};
endfunction

function automatic reg_idx_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[4:0];
endfunction

// random offset with a forced sign bit.
function automatic logic [20:0] rand_offset(input logic neg);
    logic [31:0] r;
    r = $random(seed);
    r[20] = neg;
    return r[20:0];
endfunction

function automatic word_t sign_ext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

task automatic expect_result(input op_t e_op, input reg_idx_t e_rs1, input reg_idx_t e_rs2,
                             input reg_idx_t e_rd, input word_t e_imm, input logic e_has);
    check("out_valid", 32'd1, out_valid);
    check("op", e_op, op);
    check("rs1", e_rs1, rs1);
    check("rs2", e_rs2, rs2);
    check("rd", e_rd, rd);
    check("imm", e_imm, imm);
    check("has_imm", e_has, has_imm);
endtask

task automatic reset_and_stream();
    reg_idx_t    a [4];
    reg_idx_t    d [4];
    logic [11:0] v [4];
    logic [20:0] r;
    int          i;
    for (i = 0; i < reset_cycles; i++) begin
        @(posedge clk);
        if (i == reset_cycles - 1)
            rst <= 1'b1;
        @(negedge clk);
        check("out_valid", 32'd0, out_valid);
        check("op", op_invalid, op);
    end
    @(posedge clk);
    @(negedge clk);
    check("out_valid", 32'd0, out_valid);
    check("op", op_invalid, op);
    for (i = 0; i < 4; i++) begin
        a[i] = rand_reg();
        d[i] = rand_reg();
        r    = rand_offset(i[0]);
        v[i] = {r[20], r[10:0]};
    end
    // back to back, each result lands one edge after its word.
    for (i = 0; i < 5; i++) begin
        @(posedge clk);
        if (i < 4) begin
            in_valid <= 1'b1;
            instr    <= i_word(v[i], a[i], 3'b000, d[i], opc_op_imm);
        end else begin
            in_valid <= 1'b0;
        end
        @(negedge clk);
        if (i > 0)
            expect_result(op_add, a[i-1], '0, d[i-1], sign_ext12(v[i-1]), 1'b1);
    end
    @(posedge clk);
    @(negedge clk);
    check("out_valid", 32'd0, out_valid);
    check("rd", d[3], rd);
    check("imm", sign_ext12(v[3]), imm);
endtask

task automatic reg_op(input op_t e_op, input logic [2:0] f3, input logic alt);
    reg_idx_t a;
    reg_idx_t b;
    reg_idx_t d;
    a = rand_reg();
    b = rand_reg();
    d = rand_reg();
    apply_instr(r_word(alt ? 7'b0100000 : 7'b0000000, b, a, f3, d, opc_op));
    expect_result(e_op, a, b, d, '0, 1'b0);
endtask

task automatic reg_reg_ops();
    reg_op(op_add, 3'b000, 1'b0);
    reg_op(op_sub, 3'b000, 1'b1);
    reg_op(op_sll, 3'b001, 1'b0);
    reg_op(op_slt, 3'b010, 1'b0);
    reg_op(op_sltu, 3'b011, 1'b0);
    reg_op(op_xor, 3'b100, 1'b0);
    reg_op(op_srl, 3'b101, 1'b0);
    reg_op(op_sra, 3'b101, 1'b1);
    reg_op(op_or, 3'b110, 1'b0);
    reg_op(op_and, 3'b111, 1'b0);
endtask

task automatic i_op(input op_t e_op, input opcode_t opc, input logic [2:0] f3, input logic neg);
    reg_idx_t    a;
    reg_idx_t    d;
    logic [20:0] v;
    a = rand_reg();
    d = rand_reg();
    v = rand_offset(1'b0);
    v[11] = neg;
    apply_instr(i_word(v[11:0], a, f3, d, opc));
    expect_result(e_op, a, '0, d, sign_ext12(v[11:0]), 1'b1);
endtask

task automatic shift_op(input op_t e_op, input logic [2:0] f3, input logic alt);
    reg_idx_t a;
    reg_idx_t d;
    reg_idx_t sh;
    a  = rand_reg();
    d  = rand_reg();
    sh = rand_reg();
    // alt lands on instruction bit 30.
    apply_instr(i_word({1'b0, alt, 5'b00000, sh}, a, f3, d, opc_op_imm));
    expect_result(e_op, a, '0, d, {27'b0, sh}, 1'b1);
endtask

task automatic imm_alu_ops();
    int n;
    for (n = 0; n < 2; n++) begin
        i_op(op_add, opc_op_imm, 3'b000, n == 0);
        i_op(op_slt, opc_op_imm, 3'b010, n == 0);
        i_op(op_sltu, opc_op_imm, 3'b011, n == 0);
        i_op(op_xor, opc_op_imm, 3'b100, n == 0);
        i_op(op_or, opc_op_imm, 3'b110, n == 0);
        i_op(op_and, opc_op_imm, 3'b111, n == 0);
    end
    shift_op(op_sll, 3'b001, 1'b0);
    shift_op(op_srl, 3'b101, 1'b0);
    shift_op(op_sra, 3'b101, 1'b1);
endtask

task automatic store_op(input op_t e_op, input logic [2:0] f3, input logic neg);
    reg_idx_t    a;
    reg_idx_t    b;
    logic [20:0] v;
    a = rand_reg();
    b = rand_reg();
    v = rand_offset(1'b0);
    v[11] = neg;
    apply_instr(s_word(v[11:0], b, a, f3));
    expect_result(e_op, a, b, '0, sign_ext12(v[11:0]), 1'b1);
endtask

task automatic load_store_ops();
    i_op(op_lb, opc_load, 3'b000, 1'b1);
    i_op(op_lh, opc_load, 3'b001, 1'b0);
    i_op(op_lw, opc_load, 3'b010, 1'b1);
    i_op(op_lbu, opc_load, 3'b100, 1'b0);
    i_op(op_lhu, opc_load, 3'b101, 1'b1);
    store_op(op_sb, 3'b000, 1'b1);
    store_op(op_sh, 3'b001, 1'b0);
    store_op(op_sw, 3'b010, 1'b1);
endtask

task automatic branch_op(input op_t e_op, input logic [2:0] f3, input logic neg);
    reg_idx_t    a;
    reg_idx_t    b;
    logic [20:0] v;
    a = rand_reg();
    b = rand_reg();
    v = rand_offset(1'b0);
    v[12] = neg;
    v[0]  = 1'b0;
    apply_instr(b_word(v[12:0], b, a, f3));
    expect_result(e_op, a, b, '0, {{19{v[12]}}, v[12:0]}, 1'b1);
endtask

task automatic jump_upper_ops(input logic neg);
    reg_idx_t    d;
    logic [20:0] v;
    d = rand_reg();
    v = rand_offset(neg);
    v[0] = 1'b0;
    apply_instr(j_word(v, d));
    expect_result(op_jal, '0, '0, d, {{11{v[20]}}, v}, 1'b1);
    i_op(op_jalr, opc_jalr, 3'b000, neg);
    d = rand_reg();
    v = rand_offset(neg);
    apply_instr({v[20:1], d, opc_lui});
    expect_result(op_lui, '0, '0, d, {v[20:1], 12'b0}, 1'b1);
    d = rand_reg();
    v = rand_offset(neg);
    apply_instr({v[20:1], d, opc_auipc});
    expect_result(op_auipc, '0, '0, d, {v[20:1], 12'b0}, 1'b1);
endtask

task automatic control_flow_ops();
    int n;
    for (n = 0; n < 2; n++) begin
        branch_op(op_beq, 3'b000, n == 0);
        branch_op(op_bne, 3'b001, n == 0);
        branch_op(op_blt, 3'b100, n == 0);
        branch_op(op_bge, 3'b101, n == 0);
        branch_op(op_bltu, 3'b110, n == 0);
        branch_op(op_bgeu, 3'b111, n == 0);
        jump_upper_ops(n == 0);
    end
endtask

task automatic invalid_words();
    instr_t w;
    apply_instr('0);
    expect_result(op_invalid, '0, '0, '0, '0, 1'b0);
    w = $random(seed);
    w[6:0] = 7'b1111111;
    apply_instr(w);
    expect_result(op_invalid, '0, '0, '0, '0, 1'b0);
    apply_instr(i_word(12'h7f0, rand_reg(), 3'b011, rand_reg(), opc_load));
    expect_result(op_invalid, '0, '0, '0, '0, 1'b0);
    // xor has no bit 30 variant.
    apply_instr(r_word(7'b0100000, rand_reg(), rand_reg(), 3'b100, rand_reg(), opc_op));
    expect_result(op_invalid, '0, '0, '0, '0, 1'b0);
endtask

`endif

//--- sim/tb_rv_decoder.sv
`timescale 1ns/1ps

module tb_rv_decoder;
    import rv_decode_pkg::*;

    // drive cycles of all tests, reset not counted.
    localparam int test_cycles    = 121;
    localparam int reset_cycles   = 4;
    localparam int timeout_cycles = 2 * (test_cycles + reset_cycles);

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    instr_t   instr;
    logic     out_valid;
    op_t      op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    logic     has_imm;
    integer   seed = 32'h491c_0342;
    int       errors = 0;
    int       cycles = 0;

    always #20 clk = ~clk;

    rv_decoder DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .out_valid (out_valid),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .has_imm   (has_imm)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $fatal(1, "stopped on timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // one word for one cycle, then sample the registered result mid-cycle.
    task automatic apply_instr(input instr_t w);
        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= w;
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
    endtask

    `include "tb_tests.svh"

    initial begin
        rst      = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        reset_and_stream();
        reg_reg_ops();
        imm_alu_ops();
        load_store_ops();
        control_flow_ops();
        invalid_words();
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+sim
hdl/rv_decode_pkg.sv
hdl/op_decode.sv
hdl/imm_gen.sv
hdl/decode_stage.sv
hdl/rv_decoder.sv
sim/tb_rv_decoder.sv
